/* all.f */
hdl/cache_pkg.sv
hdl/way_ram.sv
hdl/i_cache.sv
hdl/d_port.sv
hdl/mem_arbiter.sv
hdl/main_mem.sv
hdl/fetch_mem_top.sv
dv/tb_clk_gen.sv
dv/fetch_mem_tb.sv

/* dv/fetch_mem_tb.sv */
module fetch_mem_tb;
    import cache_pkg::*;

    localparam int MEM_WORDS   = 4096;
    localparam int MEM_LATENCY = 3;
    localparam int WORD_IDX_W  = $clog2(MEM_WORDS);
    // sweep of 1024 plus about 60 transactions of at most 12 cycles, wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED  = 32'h254a73b7;

    // A, B and C share cache index 0x40
    localparam logic [31:0] ADDR_A = 32'h0000_0100;
    localparam logic [31:0] ADDR_B = 32'h0000_1100;
    localparam logic [31:0] ADDR_C = 32'h0000_2100;
    localparam logic [31:0] ADDR_D = 32'h0000_0200;
    localparam logic [31:0] ADDR_E = 32'h0000_0304;
    localparam logic [31:0] ADDR_F = 32'h0000_3ff0;

    logic              clk;
    logic              rst;
    logic              inst_en;
    fetch_addr_t       pc_next;
    fetch_addr_t       pc_f;
    logic [DATA_W-1:0] inst_rdata;
    logic              stall;
    logic              hit;
    logic              stall_f;
    logic              d_req;
    logic              d_we;
    logic [ADDR_W-1:0] d_addr;
    logic [DATA_W-1:0] d_wdata;
    logic [DATA_W-1:0] d_rdata;
    logic              d_done;
    logic              d_busy;

    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] stim_addr [10];
    logic [31:0] lfsr;
    logic [31:0] exp_inst;
    logic [31:0] exp_load;
    logic        chk_fetch;
    logic        chk_miss;
    logic        chk_load;
    logic        race_on;
    logic        stall_seen;
    logic        load_first;
    string       test_name;
    int          cycle_cnt;

    tb_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    fetch_mem_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) fetch_mem_top_i (
        .clk        (clk),
        .rst        (rst),
        .inst_en    (inst_en),
        .pc_next    (pc_next),
        .pc_f       (pc_f),
        .inst_rdata (inst_rdata),
        .stall      (stall),
        .hit        (hit),
        .stall_f    (stall_f),
        .d_req      (d_req),
        .d_we       (d_we),
        .d_addr     (d_addr),
        .d_wdata    (d_wdata),
        .d_rdata    (d_rdata),
        .d_done     (d_done),
        .d_busy     (d_busy)
    );

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
        $display(">>> FAIL");
        $fatal(1, "output mismatch");
    endtask

    fetch_hit_a: assert property (@(posedge clk) chk_fetch |-> hit)
        else report_mismatch("hit", 32'd1, 32'(hit));
    fetch_stall_a: assert property (@(posedge clk) chk_fetch |-> !stall)
        else report_mismatch("stall", 32'd0, 32'(stall));
    fetch_data_a: assert property (@(posedge clk) chk_fetch |-> inst_rdata == exp_inst)
        else report_mismatch("inst_rdata", exp_inst, inst_rdata);
    miss_stall_a: assert property (@(posedge clk) chk_miss |-> stall)
        else report_mismatch("stall on miss", 32'd1, 32'(stall));
    miss_hit_a: assert property (@(posedge clk) chk_miss |-> !hit)
        else report_mismatch("hit on miss", 32'd0, 32'(hit));
    load_data_a: assert property (@(posedge clk) chk_load && d_done |-> d_rdata == exp_load)
        else report_mismatch("d_rdata", exp_load, d_rdata);
    done_busy_a: assert property (@(posedge clk) d_done |-> !d_busy)
        else report_mismatch("busy with done", 32'd0, 32'(d_busy));
    // busy follows an accepted request by one cycle
    busy_rise_a: assert property (@(posedge clk) d_req && !d_busy |=> d_busy)
        else report_mismatch("busy after req", 32'd1, 32'(d_busy));
    // data side wins, so its load ends before the refill releases stall
    load_order_a: assert property (@(posedge clk)
        race_on && stall_seen && !stall |-> load_first || d_done)
        else report_mismatch("load done before refill", 32'd1, 32'(load_first));

    always @(posedge clk) begin
        if (!race_on) begin
            stall_seen <= 1'b0;
            load_first <= 1'b0;
        end else begin
            if (stall) stall_seen <= 1'b1;
            if (d_done) load_first <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never answered", cycle_cnt);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] next_random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};  // one step per bit
        end
        return w;
    endfunction

    function automatic logic [WORD_IDX_W-1:0] word_index(input logic [31:0] addr);
        return addr[WORD_IDX_W+1:2];
    endfunction

    function automatic bit in_range(input logic [31:0] addr);
        return {2'b00, addr[31:2]} < 32'(MEM_WORDS);
    endfunction

    task automatic issue_data_req(input logic we, input logic [31:0] addr,
                                  input logic [31:0] data);
        @(posedge clk);
        #2;
        d_req   = 1'b1;
        d_we    = we;
        d_addr  = addr;
        d_wdata = data;
        @(posedge clk);
        #2;
        d_req = 1'b0;
        do @(negedge clk); while (!d_done);
        @(posedge clk);
        #2;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
        if (in_range(addr)) begin
            shadow[word_index(addr)] = data;
        end
        issue_data_req(1'b1, addr, data);
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] expected);
        exp_load = expected;
        chk_load = 1'b1;
        issue_data_req(1'b0, addr, '0);
        chk_load = 1'b0;
    endtask

    // pc_next one cycle ahead of pc_f, as the core does
    task automatic fetch(input logic [31:0] addr, input bit expect_hit,
                         input logic [31:0] expected);
        @(posedge clk);
        #2;
        pc_next.raw = addr;
        @(posedge clk);
        #2;
        pc_f.raw  = addr;
        inst_en   = 1'b1;
        exp_inst  = expected;
        chk_fetch = expect_hit;
        chk_miss  = !expect_hit;
        @(posedge clk);
        #2;
        chk_fetch = 1'b0;
        chk_miss  = 1'b0;
        if (!expect_hit) begin
            do @(negedge clk); while (stall);
            chk_fetch = 1'b1;  // refilled word comes back on this hit
            @(posedge clk);
            #2;
            chk_fetch = 1'b0;
        end
        inst_en = 1'b0;
    endtask

    initial begin
        logic [31:0] old_word;
        inst_en     = 1'b0;
        pc_next.raw = '0;
        pc_f.raw    = '0;
        stall_f     = 1'b0;
        d_req       = 1'b0;
        d_we        = 1'b0;
        d_addr      = '0;
        d_wdata     = '0;
        chk_fetch   = 1'b0;
        chk_miss    = 1'b0;
        chk_load    = 1'b0;
        race_on     = 1'b0;
        exp_inst    = '0;
        exp_load    = '0;
        lfsr        = SEED;
        test_name   = "reset";
        stim_addr   = '{ADDR_A, ADDR_B, ADDR_C, ADDR_D, ADDR_E, ADDR_F,
                        32'h0000_0004, 32'h0000_0840, 32'h0000_1ffc, 32'h0000_2a58};

        // reset, then the cache tag sweep
        do @(negedge clk); while (rst || !stall);
        do @(negedge clk); while (stall);

        test_name = "store_load";
        foreach (stim_addr[i]) store_word(stim_addr[i], next_random_word());
        foreach (stim_addr[i]) load_word(stim_addr[i], shadow[word_index(stim_addr[i])]);

        test_name = "out_of_range";
        store_word(32'h0000_4100, next_random_word());  // would alias A in memory
        load_word(32'h0000_4000, '0);
        load_word(32'hffff_fffc, '0);
        load_word(ADDR_A, shadow[word_index(ADDR_A)]);

        test_name = "cold_miss";
        fetch(ADDR_D, 1'b0, shadow[word_index(ADDR_D)]);
        test_name = "refetch_hit";
        fetch(ADDR_D, 1'b1, shadow[word_index(ADDR_D)]);

        test_name = "lru_replace";
        fetch(ADDR_A, 1'b0, shadow[word_index(ADDR_A)]);
        fetch(ADDR_B, 1'b0, shadow[word_index(ADDR_B)]);
        fetch(ADDR_A, 1'b1, shadow[word_index(ADDR_A)]);
        fetch(ADDR_C, 1'b0, shadow[word_index(ADDR_C)]);
        fetch(ADDR_A, 1'b1, shadow[word_index(ADDR_A)]);
        fetch(ADDR_B, 1'b0, shadow[word_index(ADDR_B)]);

        test_name = "arbitration";
        race_on = 1'b1;
        fork
            fetch(ADDR_E, 1'b0, shadow[word_index(ADDR_E)]);
            begin
                @(posedge clk);  // line up req with the miss cycle
                load_word(ADDR_F, shadow[word_index(ADDR_F)]);
            end
        join
        race_on = 1'b0;

        test_name = "no_coherence";
        old_word = shadow[word_index(ADDR_D)];
        store_word(ADDR_D, next_random_word());
        fetch(ADDR_D, 1'b1, old_word);  // stale line stays
        load_word(ADDR_D, shadow[word_index(ADDR_D)]);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;  // released just after the edge
    end

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // fetch address split, cache depth follows from index width
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 10;
    localparam int OFFSET_W = 2;
    localparam int SETS     = 1 << INDEX_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;  // byte within word, unused by one-word lines
    } fetch_fields_t;

    // same word seen two ways: raw for memory, fields for the cache
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     f;
    } fetch_addr_t;

    // read address channel
    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic [7:0]        arlen;  // beats minus one, always zero here
        logic              arvalid;
    } rd_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              rvalid;
        logic              rlast;
    } rd_rsp_t;

    // single-beat write, address and data together
    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic [DATA_W-1:0] wdata;
        logic [3:0]        wstrb;
        logic              wvalid;
    } wr_req_t;

    typedef struct packed {
        logic bvalid;  // one-cycle pulse
    } wr_rsp_t;

endpackage

/* hdl/d_port.sv */
module d_port #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  logic                         we,
    input  logic [cache_pkg::ADDR_W-1:0] addr,
    input  logic [cache_pkg::DATA_W-1:0] wdata,
    output logic [cache_pkg::DATA_W-1:0] rdata,
    output logic                         done,
    output logic                         busy,
    output cache_pkg::rd_req_t           rd_req,
    input  logic                         arready,
    input  cache_pkg::rd_rsp_t           rd_rsp,
    output logic                         rready,
    output cache_pkg::wr_req_t           wr_req,
    input  logic                         wready,
    input  cache_pkg::wr_rsp_t           wr_rsp
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOCAL,  // out of range, no bus cycle
        AR,
        R,
        W,
        B
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              in_range;

    assign in_range = addr[ADDR_W-1:2] < MEM_WORDS;
    assign busy     = (state != IDLE);

    assign rd_req.araddr  = addr_q;
    assign rd_req.arlen   = 8'd0;
    assign rd_req.arvalid = (state == AR);
    assign rready         = (state == R);

    assign wr_req.awaddr = addr_q;
    assign wr_req.wdata  = wdata_q;
    assign wr_req.wstrb  = 4'hf;  // full-word stores only
    assign wr_req.wvalid = (state == W);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= !in_range ? LOCAL : (we ? W : AR);
                    end
                end
                LOCAL: begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
                AR: if (arready) state <= R;
                R: begin
                    if (rd_rsp.rvalid && rd_rsp.rlast) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                W: if (wready) state <= B;
                B: begin
                    if (wr_rsp.bvalid) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == LOCAL) begin
            rdata <= '0;
        end else if ((state == R) && rd_rsp.rvalid) begin
            rdata <= rd_rsp.rdata;
        end
    end

endmodule

/* hdl/fetch_mem_top.sv */
module fetch_mem_top #(
    parameter int MEM_WORDS   = 4096,
    parameter int MEM_LATENCY = 3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_en,
    input  cache_pkg::fetch_addr_t       pc_next,
    input  cache_pkg::fetch_addr_t       pc_f,
    output logic [cache_pkg::DATA_W-1:0] inst_rdata,
    output logic                         stall,
    output logic                         hit,
    input  logic                         stall_f,
    input  logic                         d_req,
    input  logic                         d_we,
    input  logic [cache_pkg::ADDR_W-1:0] d_addr,
    input  logic [cache_pkg::DATA_W-1:0] d_wdata,
    output logic [cache_pkg::DATA_W-1:0] d_rdata,
    output logic                         d_done,
    output logic                         d_busy
);
    import cache_pkg::*;

    rd_req_t i_rd_req;
    rd_req_t d_rd_req;
    rd_req_t m_rd_req;
    rd_rsp_t i_rd_rsp;
    rd_rsp_t d_rd_rsp;
    rd_rsp_t m_rd_rsp;
    wr_req_t d_wr_req;
    wr_req_t m_wr_req;
    wr_rsp_t d_wr_rsp;
    wr_rsp_t m_wr_rsp;
    logic    i_arready;
    logic    i_rready;
    logic    d_arready;
    logic    d_rready;
    logic    d_wready;
    logic    m_arready;
    logic    m_rready;
    logic    m_wready;

    i_cache i_cache_i (
        .clk        (clk),
        .rst        (rst),
        .inst_en    (inst_en),
        .pc_next    (pc_next),
        .pc_f       (pc_f),
        .inst_rdata (inst_rdata),
        .stall      (stall),
        .hit        (hit),
        .stall_f    (stall_f),
        .rd_req     (i_rd_req),
        .arready    (i_arready),
        .rd_rsp     (i_rd_rsp),
        .rready     (i_rready)
    );

    d_port #(
        .MEM_WORDS (MEM_WORDS)
    ) d_port_i (
        .clk     (clk),
        .rst     (rst),
        .req     (d_req),
        .we      (d_we),
        .addr    (d_addr),
        .wdata   (d_wdata),
        .rdata   (d_rdata),
        .done    (d_done),
        .busy    (d_busy),
        .rd_req  (d_rd_req),
        .arready (d_arready),
        .rd_rsp  (d_rd_rsp),
        .rready  (d_rready),
        .wr_req  (d_wr_req),
        .wready  (d_wready),
        .wr_rsp  (d_wr_rsp)
    );

    mem_arbiter mem_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .i_rd_req  (i_rd_req),
        .i_arready (i_arready),
        .i_rd_rsp  (i_rd_rsp),
        .i_rready  (i_rready),
        .d_rd_req  (d_rd_req),
        .d_arready (d_arready),
        .d_rd_rsp  (d_rd_rsp),
        .d_rready  (d_rready),
        .d_wr_req  (d_wr_req),
        .d_wready  (d_wready),
        .d_wr_rsp  (d_wr_rsp),
        .m_rd_req  (m_rd_req),
        .m_arready (m_arready),
        .m_rd_rsp  (m_rd_rsp),
        .m_rready  (m_rready),
        .m_wr_req  (m_wr_req),
        .m_wready  (m_wready),
        .m_wr_rsp  (m_wr_rsp)
    );

    main_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) main_mem_i (
        .clk     (clk),
        .rst     (rst),
        .rd_req  (m_rd_req),
        .arready (m_arready),
        .rd_rsp  (m_rd_rsp),
        .rready  (m_rready),
        .wr_req  (m_wr_req),
        .wready  (m_wready),
        .wr_rsp  (m_wr_rsp)
    );

endmodule

/* hdl/i_cache.sv */
module i_cache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_en,
    input  cache_pkg::fetch_addr_t       pc_next,
    input  cache_pkg::fetch_addr_t       pc_f,
    output logic [cache_pkg::DATA_W-1:0] inst_rdata,
    output logic                         stall,
    output logic                         hit,
    input  logic                         stall_f,
    output cache_pkg::rd_req_t           rd_req,
    input  logic                         arready,
    input  cache_pkg::rd_rsp_t           rd_rsp,
    output logic                         rready
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        HIT_JUDGE,
        LOAD,
        REFILL
    } state_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

    state_t             state;
    tag_entry_t         tag_q [2];
    tag_entry_t         tag_d;
    logic [DATA_W-1:0]  data_q [2];
    logic [DATA_W-1:0]  refill_word;
    logic [1:0]         way_hit;
    logic [1:0]         en_way;
    logic [1:0]         we_way;
    logic [INDEX_W-1:0] ram_addr;
    logic [INDEX_W-1:0] clr_cnt;
    logic [SETS-1:0]    lru;  // 0 -> replace way0 next
    logic               raw_hit;
    logic               sel;
    logic               evict;
    logic               miss_req;
    logic               addr_rcv;  // address handshake done
    logic               read_done;

    assign raw_hit    = |way_hit;
    assign sel        = way_hit[1];
    assign hit        = (state == HIT_JUDGE) && raw_hit;
    assign miss_req   = (state == HIT_JUDGE) && inst_en && !raw_hit;
    assign evict      = lru[pc_f.f.index];
    assign inst_rdata = data_q[sel];

    // low in IDLE, high for the whole sweep and any refill
    assign stall = miss_req || (state inside {CLEAR, LOAD, REFILL});

    // ram index: sweep counter, refill target, or lookahead for next fetch
    always_comb begin
        case (state)
            CLEAR:   ram_addr = clr_cnt;
            REFILL:  ram_addr = pc_f.f.index;
            default: ram_addr = pc_next.f.index;
        endcase
    end

    assign tag_d = (state == CLEAR) ? tag_entry_t'('0)
                                    : tag_entry_t'{tag: pc_f.f.tag, valid: 1'b1};

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign way_hit[w] = tag_q[w].valid && (tag_q[w].tag == pc_f.f.tag);
        assign we_way[w]  = (state == CLEAR) || ((state == REFILL) && (evict == 1'(w)));
        // hold dout on a miss or a core stall so the compare stays alive
        assign en_way[w]  = we_way[w] || ((state == HIT_JUDGE) && !stall_f && !miss_req);

        way_ram #(
            .WIDTH ($bits(tag_entry_t)),
            .DEPTH (SETS)
        ) tag_ram (
            .clk  (clk),
            .en   (en_way[w]),
            .we   (we_way[w]),
            .addr (ram_addr),
            .din  (tag_d),
            .dout (tag_q[w])
        );

        way_ram #(
            .WIDTH (DATA_W),
            .DEPTH (SETS)
        ) data_ram (
            .clk  (clk),
            .en   (en_way[w]),
            .we   (we_way[w]),
            .addr (ram_addr),
            .din  (refill_word),  // don't care during the sweep
            .dout (data_q[w])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            clr_cnt  <= '0;
            addr_rcv <= 1'b0;
            lru      <= '0;
        end else begin
            case (state)
                IDLE: state <= CLEAR;
                CLEAR: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (&clr_cnt) begin
                        state <= HIT_JUDGE;
                    end
                end
                HIT_JUDGE: begin
                    if (miss_req) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (rd_req.arvalid && arready) begin
                        addr_rcv <= 1'b1;
                    end
                    if (read_done) begin
                        addr_rcv <= 1'b0;
                        state    <= REFILL;
                    end
                end
                REFILL: state <= HIT_JUDGE;  // one write cycle
                default: state <= IDLE;
            endcase

            if (hit) begin
                lru[pc_f.f.index] <= ~sel;  // point at the way not used
            end else if (state == REFILL) begin
                lru[pc_f.f.index] <= ~evict;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_done) begin
            refill_word <= rd_rsp.rdata;
        end
    end

    // refill read channel, one beat of the missing word
    assign read_done      = rd_rsp.rvalid && rready && rd_rsp.rlast;
    assign rd_req.araddr  = pc_f.raw;
    assign rd_req.arlen   = 8'd0;
    assign rd_req.arvalid = (state == LOAD) && !addr_rcv;
    assign rready         = (state == LOAD) && addr_rcv;

endmodule

/* hdl/main_mem.sv */
module main_mem #(
    parameter int MEM_WORDS   = 4096,
    parameter int MEM_LATENCY = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::rd_req_t rd_req,
    output logic               arready,
    output cache_pkg::rd_rsp_t rd_rsp,
    input  logic               rready,
    input  cache_pkg::wr_req_t wr_req,
    output logic               wready,
    output cache_pkg::wr_rsp_t wr_rsp
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY) + 1;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [CNT_W-1:0]  cnt;
    logic              busy;
    logic              is_write;
    logic              respond;

    // word index, byte offset dropped
    assign rd_idx = rd_req.araddr[IDX_W+1:2];
    assign wr_idx = wr_req.awaddr[IDX_W+1:2];

    assign arready = !busy;
    assign wready  = !busy;
    assign respond = busy && (cnt == '0);

    assign rd_rsp.rdata  = rdata_q;
    assign rd_rsp.rvalid = respond && !is_write;  // held until rready
    assign rd_rsp.rlast  = respond && !is_write;
    assign wr_rsp.bvalid = respond && is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            is_write <= 1'b0;
            cnt      <= '0;
        end else if (!busy) begin
            if (wr_req.wvalid || rd_req.arvalid) begin
                busy     <= 1'b1;
                is_write <= wr_req.wvalid;
                cnt      <= CNT_W'(MEM_LATENCY - 1);
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (is_write || rready) begin
            busy <= 1'b0;
        end
    end

    // storage, write applied and read data taken at acceptance
    always_ff @(posedge clk) begin
        if (!busy && wr_req.wvalid) begin
            for (int b = 0; b < $bits(wr_req.wstrb); b++) begin
                if (wr_req.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_req.wdata[8*b +: 8];
                end
            end
        end else if (!busy && rd_req.arvalid) begin
            rdata_q <= mem[rd_idx];
        end
    end

endmodule

/* hdl/mem_arbiter.sv */
module mem_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::rd_req_t i_rd_req,
    output logic               i_arready,
    output cache_pkg::rd_rsp_t i_rd_rsp,
    input  logic               i_rready,
    input  cache_pkg::rd_req_t d_rd_req,
    output logic               d_arready,
    output cache_pkg::rd_rsp_t d_rd_rsp,
    input  logic               d_rready,
    input  cache_pkg::wr_req_t d_wr_req,
    output logic               d_wready,
    output cache_pkg::wr_rsp_t d_wr_rsp,
    output cache_pkg::rd_req_t m_rd_req,
    input  logic               m_arready,
    input  cache_pkg::rd_rsp_t m_rd_rsp,
    output logic               m_rready,
    output cache_pkg::wr_req_t m_wr_req,
    input  logic               m_wready,
    input  cache_pkg::wr_rsp_t m_wr_rsp
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_D,
        OWN_I
    } owner_t;

    owner_t owner;
    logic   d_want;
    logic   sel_d;
    logic   sel_i;
    logic   last_beat;

    // grant combinationally while idle, data side first
    assign d_want = d_rd_req.arvalid || d_wr_req.wvalid;
    assign sel_d  = (owner == OWN_D) || ((owner == OWN_NONE) && d_want);
    assign sel_i  = (owner == OWN_I) || ((owner == OWN_NONE) && !d_want && i_rd_req.arvalid);

    assign last_beat = (m_rd_rsp.rvalid && m_rready && m_rd_rsp.rlast) || m_wr_rsp.bvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else if (owner == OWN_NONE) begin
            if (sel_d) begin
                owner <= OWN_D;
            end else if (sel_i) begin
                owner <= OWN_I;
            end
        end else if (last_beat) begin
            owner <= OWN_NONE;  // free again next cycle
        end
    end

    // non-owner requests masked toward memory
    assign m_rd_req = sel_d ? d_rd_req : (sel_i ? i_rd_req : '0);
    assign m_wr_req = sel_d ? d_wr_req : '0;
    assign m_rready = sel_d ? d_rready : (sel_i && i_rready);

    assign d_arready = sel_d && m_arready;
    assign d_wready  = sel_d && m_wready;
    assign i_arready = sel_i && m_arready;  // loser waits with ready low

    assign d_rd_rsp = sel_d ? m_rd_rsp : '0;
    assign d_wr_rsp = sel_d ? m_wr_rsp : '0;
    assign i_rd_rsp = sel_i ? m_rd_rsp : '0;

endmodule

/* hdl/way_ram.sv */
module way_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 1024
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // write-first, dout holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
                dout      <= din;  // new word visible next cycle
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the fetch/memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fetch_mem_tb \
    -f all.f -o fetch_mem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/fetch_mem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
